// ==== tb.f ====
hw/muldiv_pkg.sv
hw/int_div_sign_unit.sv
hw/int_div_iter_dpath.sv
hw/int_div_iter_ctrl.sv
hw/int_div_iter.sv
dv/tb_int_div_iter.sv

// ==== Bender.yml ====
package:
  name: int_div_iter

sources:
  # package first, then the RTL bottom up
  - hw/muldiv_pkg.sv
  - hw/int_div_sign_unit.sv
  - hw/int_div_iter_dpath.sv
  - hw/int_div_iter_ctrl.sv
  - hw/int_div_iter.sv

  # testbench, top module tb_int_div_iter
  - target: simulation
    files:
      - dv/tb_int_div_iter.sv

// ==== dv/tb_int_div_iter.sv ====
/*
 * directed testbench for the iterative divider with a reference model,
 * request/response tasks, clock, timeout and checks
 */

`timescale 1ns/1ns

module tb_int_div_iter;

  import muldiv_pkg::*;

  localparam int WIDTH       = DIV_WIDTH;
  localparam int DRIVE_DELAY = 10;
  localparam int N_RANDOM    = 50;
  // latency test, unsigned, signed, divide by zero, back-pressure
  localparam int NUM_REQ     = 1 + (7 + N_RANDOM) + (7 + N_RANDOM) + 4 + 5;
  localparam int CYCLE_LIMIT = 40 * NUM_REQ + 200;

  logic               clk;
  logic               reset;
  div_fn_e            req_fn;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  logic               req_val;
  logic               req_rdy;
  logic [2*WIDTH-1:0] resp_result;
  logic               resp_val;
  logic               resp_rdy;

  int cycle_count;
  int errors;
  int seed_val;

  int_div_iter #(
    .WIDTH (WIDTH)
  ) dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------
  // clock and run limit
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("tests failed");
      $fatal(1, "timeout: run exceeded %0d cycles", CYCLE_LIMIT);
    end
  end

  // ----------------------------------------
  // reference model and checks
  // ----------------------------------------

  // {remainder, quotient} straight from the result rules
  function automatic logic [2*WIDTH-1:0] expected_result(input div_fn_e fn,
                                                         input logic [WIDTH-1:0] a,
                                                         input logic [WIDTH-1:0] b);
    longint           sa;
    longint           sb;
    longint           lq;
    longint           lr;
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (fn == DIV_UNSIGNED) begin
      q = a / b;
      r = a % b;
    end else begin
      // 64 bit math so min / -1 wraps back onto the min value
      sa = $signed(a);
      sb = $signed(b);
      lq = sa / sb;
      lr = sa % sb;
      q  = lq[WIDTH-1:0];
      r  = lr[WIDTH-1:0];
    end
    return {r, q};
  endfunction

  task automatic stop_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    string msg;
    assert (got === exp) else begin
      msg = $sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      stop_run(msg);
    end
  endtask

  // ----------------------------------------
  // one division through the handshake
  // ----------------------------------------

  // hold > 0 keeps resp_rdy low for that many cycles once resp_val is up
  task automatic run_div(input div_fn_e fn, input logic [WIDTH-1:0] a,
                         input logic [WIDTH-1:0] b, input int hold);
    logic [2*WIDTH-1:0] exp_res;
    logic [2*WIDTH-1:0] held;
    int                 cycles;
    int                 wait_cycles;
    int                 i;
    exp_res     = expected_result(fn, a, b);
    wait_cycles = 0;
    while (!req_rdy) begin
      assert (wait_cycles < 10) else stop_run("request side never became ready");
      @(posedge clk);
      #DRIVE_DELAY;
      wait_cycles++;
    end
    resp_rdy = (hold == 0);
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    req_val = 1'b0;
    // junk on the operand lines, only the accepting cycle counts
    req_a = $urandom();
    req_b = $urandom();
    check_value("req_rdy", req_rdy, 0);
    // counted from the accepting cycle
    cycles = 1;
    while (!resp_val) begin
      assert (cycles <= WIDTH + 4) else stop_run("response never arrived after request");
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    check_value("resp_val latency", cycles, WIDTH + 1);
    check_value("resp_result quotient", resp_result[WIDTH-1:0], exp_res[WIDTH-1:0]);
    check_value("resp_result remainder", resp_result[2*WIDTH-1:WIDTH],
                exp_res[2*WIDTH-1:WIDTH]);
    held = resp_result;
    for (i = 0; i < hold; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("resp_val", resp_val, 1);
      check_value("req_rdy", req_rdy, 0);
      check_value("resp_result", resp_result, held);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    // response taken, divider ready again
    check_value("resp_val", resp_val, 0);
    check_value("req_rdy", req_rdy, 1);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset_latency();
    check_value("req_rdy", req_rdy, 1);
    check_value("resp_val", resp_val, 0);
    run_div(DIV_UNSIGNED, 32'd100, 32'd7, 0);
  endtask

  task automatic test_unsigned();
    int k;
    run_div(DIV_UNSIGNED, 32'd100, 32'd7, 0);
    run_div(DIV_UNSIGNED, 32'd7, 32'd100, 0);
    run_div(DIV_UNSIGNED, 32'hFFFF_FFFF, 32'd1, 0);
    run_div(DIV_UNSIGNED, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    run_div(DIV_UNSIGNED, 32'h8000_0000, 32'd3, 0);
    run_div(DIV_UNSIGNED, 32'h1234_5678, 32'd1000, 0);
    run_div(DIV_UNSIGNED, 32'd0, 32'd5, 0);
    // divisor shifted down so small divisors show up too
    for (k = 0; k < N_RANDOM; k++) begin
      run_div(DIV_UNSIGNED, $urandom(), $urandom() >> $urandom_range(31, 0), 0);
    end
  endtask

  task automatic test_signed();
    int k;
    // all four sign combinations
    run_div(DIV_SIGNED, 32'd7, 32'd2, 0);
    run_div(DIV_SIGNED, -32'sd7, 32'd2, 0);
    run_div(DIV_SIGNED, 32'd7, -32'sd2, 0);
    run_div(DIV_SIGNED, -32'sd7, -32'sd2, 0);
    // most negative value cases
    run_div(DIV_SIGNED, 32'h8000_0000, 32'hFFFF_FFFF, 0);
    run_div(DIV_SIGNED, 32'h8000_0000, 32'd1, 0);
    run_div(DIV_SIGNED, -32'sd1, 32'h8000_0000, 0);
    // arithmetic shift keeps the divisor sign
    for (k = 0; k < N_RANDOM; k++) begin
      run_div(DIV_SIGNED, $urandom(), $signed($urandom()) >>> $urandom_range(31, 0), 0);
    end
  endtask

  task automatic test_div_zero();
    // both functions, with a negative dividend under signed
    run_div(DIV_UNSIGNED, 32'd1234, 32'd0, 0);
    run_div(DIV_UNSIGNED, 32'hFFFF_FFFF, 32'd0, 0);
    run_div(DIV_SIGNED, 32'd5, 32'd0, 0);
    run_div(DIV_SIGNED, -32'sd5, 32'd0, 0);
  endtask

  task automatic test_backpressure();
    int k;
    for (k = 0; k < 5; k++) begin
      run_div(div_fn_e'($urandom_range(1, 0)), $urandom(), $urandom_range(1000, 1),
              $urandom_range(10, 1));
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    errors   = 0;
    seed_val = $urandom(47);
    reset    = 1'b1;
    req_fn   = DIV_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    test_reset_latency();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_backpressure();

    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== hw/int_div_iter.sv ====
/*
 * iterative integer divider top level joining control and datapath
 */

`timescale 1ns/1ns

module int_div_iter #(
  parameter int WIDTH = muldiv_pkg::DIV_WIDTH
) (
  input  logic                 clk,
  input  logic                 reset,

  // request side
  input  muldiv_pkg::div_fn_e  req_fn,
  input  logic [WIDTH-1:0]     req_a,
  input  logic [WIDTH-1:0]     req_b,
  input  logic                 req_val,
  output logic                 req_rdy,

  // response side, {remainder, quotient}
  output logic [2*WIDTH-1:0]   resp_result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;

  // ----------------------------------------
  // control unit
  // ----------------------------------------

  int_div_iter_ctrl #(
    .WIDTH (WIDTH)
  ) ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en)
  );

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  int_div_iter_dpath #(
    .WIDTH (WIDTH)
  ) dpath0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .a_mux_sel   (a_mux_sel),
    .b_en        (b_en),
    .resp_result (resp_result)
  );

endmodule

// ==== hw/int_div_iter_ctrl.sv ====
/*
 * divider control unit, IDLE/CALC/DONE FSM with the step counter,
 * datapath enables and the val/rdy handshake outputs
 */

`timescale 1ns/1ns

module int_div_iter_ctrl #(
  parameter int WIDTH = muldiv_pkg::DIV_WIDTH
) (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en
);

  import muldiv_pkg::*;

  localparam int            CW   = count_width(WIDTH);
  localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e        state;
  logic [CW-1:0] count;
  logic          req_go;
  logic          resp_go;

  // handshake outputs straight from the state
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // state and step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // WIDTH steps, one per edge
          if (count == LAST) begin
            state <= DONE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // result held until the consumer takes it
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
          count <= '0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath enables
  // ----------------------------------------

  // load on the accepting edge, step through CALC, idle otherwise
  assign a_en      = req_go || (state == CALC);
  assign a_mux_sel = (state == CALC);
  assign b_en      = req_go;

  a_no_rdy_and_val: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  );

  a_count_range: assert property (
    @(posedge clk) disable iff (reset) (state == CALC) |-> (count <= LAST)
  );

endmodule

// ==== hw/int_div_iter_dpath.sv ====
/*
 * divider datapath with the request registers, the shift/subtract
 * remainder and quotient register, the divisor register and result assembly
 */

`timescale 1ns/1ns

module int_div_iter_dpath #(
  parameter int WIDTH = muldiv_pkg::DIV_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  muldiv_pkg::div_fn_e   req_fn,
  input  logic [WIDTH-1:0]      req_a,
  input  logic [WIDTH-1:0]      req_b,
  input  logic                  a_en,
  input  logic                  a_mux_sel,
  input  logic                  b_en,
  output logic [2*WIDTH-1:0]    resp_result
);

  import muldiv_pkg::*;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // request fields held for the result correction in DONE
  div_fn_e          fn_reg;
  logic [WIDTH-1:0] a_raw_reg;
  logic [WIDTH-1:0] b_raw_reg;

  // {remainder (WIDTH+1 bits), quotient (WIDTH bits)}
  logic [2*WIDTH:0] a_reg;
  // divisor magnitude sitting over the remainder half
  logic [2*WIDTH:0] b_reg;

  // ----------------------------------------
  // sign unit inputs and outputs
  // ----------------------------------------

  div_fn_e          su_fn;
  logic [WIDTH-1:0] su_a_raw;
  logic [WIDTH-1:0] su_b_raw;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [WIDTH-1:0] q_mag;
  logic [WIDTH-1:0] r_mag;
  logic [WIDTH-1:0] q_out;
  logic [WIDTH-1:0] r_out;

  // ----------------------------------------
  // step logic
  // ----------------------------------------

  logic [2*WIDTH:0] a_init;
  logic [2*WIDTH:0] a_shift;
  logic [2*WIDTH:0] a_diff;
  logic [2*WIDTH:0] a_step;
  logic             sub_neg;

  // b_en only rises on the accepting cycle
  // then the unit sees the incoming request, otherwise the held one
  assign su_fn    = b_en ? req_fn : fn_reg;
  assign su_a_raw = b_en ? req_a  : a_raw_reg;
  assign su_b_raw = b_en ? req_b  : b_raw_reg;

  // dividend magnitude starts in the quotient half
  assign a_init = {{(WIDTH+1){1'b0}}, a_mag};

  // shift then trial subtract against the aligned divisor
  assign a_shift = a_reg << 1;
  assign a_diff  = a_shift - b_reg;
  assign sub_neg = a_diff[2*WIDTH];

  // low half of b_reg is zero so the difference keeps the shifted quotient
  // bit 0 becomes the new quotient bit
  assign a_step = sub_neg ? a_shift : {a_diff[2*WIDTH:1], 1'b1};

  always_ff @(posedge clk) begin
    if (b_en) begin
      fn_reg    <= req_fn;
      a_raw_reg <= req_a;
      b_raw_reg <= req_b;
      b_reg     <= {1'b0, b_mag, {WIDTH{1'b0}}};
    end
    if (a_en) begin
      a_reg <= a_mux_sel ? a_step : a_init;
    end
  end

  // ----------------------------------------
  // result assembly
  // ----------------------------------------

  // top bit of the remainder field is zero once the steps are done
  assign q_mag = a_reg[WIDTH-1:0];
  assign r_mag = a_reg[2*WIDTH-1:WIDTH];

  int_div_sign_unit #(
    .WIDTH (WIDTH)
  ) sign0 (
    .fn    (su_fn),
    .a_raw (su_a_raw),
    .b_raw (su_b_raw),
    .q_mag (q_mag),
    .r_mag (r_mag),
    .a_mag (a_mag),
    .b_mag (b_mag),
    .q_out (q_out),
    .r_out (r_out)
  );

  assign resp_result = {r_out, q_out};

  // divisor must hold across every step of a division
  a_divisor_stable: assert property (
    @(posedge clk) disable iff (reset)
    (a_en && a_mux_sel) |=> $stable(b_reg)
  );

endmodule

// ==== hw/int_div_sign_unit.sv ====
/*
 * sign unit for the divider, operand magnitudes on the way in,
 * result sign correction and divide-by-zero results on the way out
 */

`timescale 1ns/1ns

module int_div_sign_unit #(
  parameter int WIDTH = muldiv_pkg::DIV_WIDTH
) (
  input  muldiv_pkg::div_fn_e fn,
  input  logic [WIDTH-1:0]    a_raw,
  input  logic [WIDTH-1:0]    b_raw,
  input  logic [WIDTH-1:0]    q_mag,
  input  logic [WIDTH-1:0]    r_mag,
  output logic [WIDTH-1:0]    a_mag,
  output logic [WIDTH-1:0]    b_mag,
  output logic [WIDTH-1:0]    q_out,
  output logic [WIDTH-1:0]    r_out
);

  import muldiv_pkg::*;

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic q_neg;
  logic div_zero;

  // ----------------------------------------
  // operand signs
  // ----------------------------------------

  // sign bits only count for signed division
  assign is_signed = (fn == DIV_SIGNED);
  assign a_neg     = is_signed && a_raw[WIDTH-1];
  assign b_neg     = is_signed && b_raw[WIDTH-1];

  // quotient is negative when exactly one operand is
  assign q_neg = a_neg ^ b_neg;

  // zero divisor overrides both results
  assign div_zero = (b_raw == '0);

  // ----------------------------------------
  // magnitudes loaded on the accepting cycle
  // ----------------------------------------

  // two's complement negate
  // most negative value maps onto itself, which is its unsigned magnitude
  assign a_mag = a_neg ? (~a_raw + 1'b1) : a_raw;
  assign b_mag = b_neg ? (~b_raw + 1'b1) : b_raw;

  // ----------------------------------------
  // corrected results
  // ----------------------------------------

  always_comb begin
    if (div_zero) begin
      // all ones quotient, dividend passes through untouched
      q_out = '1;
      r_out = a_raw;
    end else begin
      q_out = q_neg ? (~q_mag + 1'b1) : q_mag;
      // remainder follows the sign of the dividend
      r_out = a_neg ? (~r_mag + 1'b1) : r_mag;
    end
  end

  // most negative / -1 needs no special case here
  // magnitude quotient is 2**(WIDTH-1), no negation, remainder zero

endmodule

// ==== hw/muldiv_pkg.sv ====
/*
 * divider package with the request function encoding,
 * the default operand width and the counter width helper
 */

package muldiv_pkg;

  // ----------------------------------------
  // request function encoding
  // ----------------------------------------

  // one bit on the request port
  // signed is the zero encoding
  typedef enum logic [0:0] {
    DIV_SIGNED   = 1'b0,
    DIV_UNSIGNED = 1'b1
  } div_fn_e;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // default operand width, top level passes it down as WIDTH
  localparam int DIV_WIDTH = 32;

  // response result is 2*WIDTH bits
  // remainder in the upper half, quotient in the lower half

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // bits needed for a step counter running 0 .. width-1
  // never below one bit so a WIDTH of 1 still builds
  function automatic int count_width(input int width);
    int bits;
    bits = (width > 1) ? $clog2(width) : 1;
    return bits;
  endfunction

endpackage
